// File: src/rs_pkg.sv
package rs_pkg;

  localparam int word_w = 32;
  localparam int rs_len = 8;
  localparam int rs_idx_w = $clog2(rs_len);
  localparam int iq_len = 32;
  localparam int iq_idx_w = 5;
  localparam int reg_len = 32;
  localparam int reg_idx_w = $clog2(reg_len);
  localparam int rs_max_ls = 4;
  // counts 0 up to rs_max_ls inclusive
  localparam int ls_cnt_w = $clog2(rs_max_ls + 1);

  // RV32I major opcodes
  typedef enum logic [6:0] {
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_calc   = 7'b0110011,
    op_calc_i = 7'b0010011,
    op_branch = 7'b1100011,
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111
  } opcode_e;

  typedef enum logic [4:0] {
    calc_add, calc_sub, calc_sll, calc_slt, calc_sltu,
    calc_xor, calc_srl, calc_sra, calc_or, calc_and,
    calc_beq, calc_bne, calc_blt, calc_bge, calc_bltu, calc_bgeu
  } calc_code_e;

  typedef struct packed {
    logic                 valid;
    logic [iq_idx_w-1:0]  iq_idx;
    opcode_e              opcode;
    logic [2:0]           func3;
    logic [6:0]           func7;
    logic [word_w-1:0]    imm;
    logic [reg_idx_w-1:0] rs1;
    logic [reg_idx_w-1:0] rs2;
    logic [reg_idx_w-1:0] rd;
    logic [word_w-1:0]    pc;
  } dispatch_req_t;

  typedef struct packed {
    logic                valid;
    logic [iq_idx_w-1:0] iq_idx;
    logic [word_w-1:0]   value;
  } cdb_t;

  typedef struct packed {
    logic                 valid;
    logic [reg_idx_w-1:0] rd;
    logic [iq_idx_w-1:0]  iq_idx;
    logic [word_w-1:0]    value;
  } commit_t;

  typedef struct packed {
    logic [iq_idx_w-1:0] head;
    logic                have_store;
    logic [iq_idx_w-1:0] first_store;
  } store_order_t;

  typedef struct packed {
    logic                waiting;
    logic [iq_idx_w-1:0] tag;
    logic [word_w-1:0]   value;
  } operand_t;

  typedef struct packed {
    logic                valid;
    logic [iq_idx_w-1:0] order;
    opcode_e             opcode;
    logic [2:0]          func3;
    logic [6:0]          func7;
    logic [word_w-1:0]   imm;
    logic [word_w-1:0]   pc;
    operand_t            src1;
    operand_t            src2;
  } rs_entry_t;

  typedef struct packed {
    logic                valid;
    calc_code_e          code;
    logic [word_w-1:0]   lhs;
    logic [word_w-1:0]   rhs;
    logic [iq_idx_w-1:0] iq_idx;
  } alu_req_t;

  typedef struct packed {
    logic                valid;
    logic [2:0]          func3;
    logic [word_w-1:0]   addr;
    logic [iq_idx_w-1:0] iq_idx;
  } lb_req_t;

  typedef struct packed {
    logic                valid;
    logic [iq_idx_w-1:0] iq_idx;
    logic [word_w-1:0]   result;
    logic                need_cdb;
    logic                has_tar;
    logic [word_w-1:0]   tar_addr;
  } iq_write_t;

  function automatic logic is_ls(opcode_e op);
    return (op == op_load) || (op == op_store);
  endfunction

  // resolve a waiting operand when its tag is on the bus
  function automatic operand_t wake(operand_t op, cdb_t bus);
    operand_t res;
    res = op;
    if (op.waiting && bus.valid && bus.iq_idx == op.tag) begin
      res.waiting = 1'b0;
      res.value = bus.value;
    end
    return res;
  endfunction

endpackage

// File: src/operand_lookup.sv
`timescale 1ns/1ns

module operand_lookup (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         clear,
  input  logic                         fire,
  input  logic [rs_pkg::reg_idx_w-1:0] rs1,
  input  logic [rs_pkg::reg_idx_w-1:0] rs2,
  input  logic [rs_pkg::reg_idx_w-1:0] rd,
  input  logic [rs_pkg::iq_idx_w-1:0]  tag,
  input  rs_pkg::cdb_t                 cdb,
  input  rs_pkg::commit_t              commit,
  output rs_pkg::operand_t             src1,
  output rs_pkg::operand_t             src2
);
  import rs_pkg::*;

  logic [word_w-1:0]   reg_val [reg_len];
  logic [reg_len-1:0]  renamed;
  logic [iq_idx_w-1:0] rename_tag [reg_len];
  // results already broadcast but not yet committed
  logic [word_w-1:0]   buf_val [iq_len];
  logic [iq_len-1:0]   buf_avl;

  function automatic operand_t lookup(logic [reg_idx_w-1:0] r);
    operand_t op;
    logic [iq_idx_w-1:0] t;
    logic commit_hit;
    t = rename_tag[r];
    commit_hit = commit.valid && commit.rd == r && r != '0;
    op.waiting = 1'b0;
    op.tag = t;
    op.value = commit_hit ? commit.value : reg_val[r];
    // a commit of the current rename resolves it in this same cycle
    if (renamed[r] && !(commit_hit && commit.iq_idx == t)) begin
      if (buf_avl[t]) begin
        op.value = buf_val[t];
      end else begin
        // a same-cycle broadcast is picked up by the dispatch stage
        op.waiting = 1'b1;
      end
    end
    return op;
  endfunction

  always_comb begin
    src1 = lookup(rs1);
    src2 = lookup(rs2);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < reg_len; i++) begin
        reg_val[i] <= '0;
      end
    end else if (commit.valid && commit.rd != '0) begin
      reg_val[commit.rd] <= commit.value;
    end
  end

  always_ff @(posedge clk) begin
    if (cdb.valid) begin
      buf_val[cdb.iq_idx] <= cdb.value;
    end
    if (fire && rd != '0) begin
      rename_tag[rd] <= tag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      renamed <= '0;
      buf_avl <= '0;
    end else begin
      if (cdb.valid) begin
        buf_avl[cdb.iq_idx] <= 1'b1;
      end
      if (commit.valid) begin
        buf_avl[commit.iq_idx] <= 1'b0;
        if (renamed[commit.rd] && rename_tag[commit.rd] == commit.iq_idx) begin
          renamed[commit.rd] <= 1'b0;
        end
      end
      // a new rename overrides a commit of the same register
      if (fire) begin
        buf_avl[tag] <= 1'b0;
        if (rd != '0) begin
          renamed[rd] <= 1'b1;
        end
      end
    end
  end

endmodule

// File: src/dispatch_stage.sv
`timescale 1ns/1ns

module dispatch_stage (
  input  logic                         clk,
  input  logic                         rst,
  input  rs_pkg::dispatch_req_t        req,
  input  logic                         commit_flag,
  input  logic                         clear,
  input  logic [rs_pkg::rs_len-1:0]    occupied,
  input  logic [rs_pkg::ls_cnt_w-1:0]  ls_count,
  input  rs_pkg::cdb_t                 cdb,
  input  rs_pkg::operand_t             src1,
  input  rs_pkg::operand_t             src2,
  output logic                         fire,
  output logic [rs_pkg::rs_idx_w-1:0]  slot,
  output rs_pkg::rs_entry_t            entry,
  output logic                         push_valid,
  output logic [rs_pkg::iq_idx_w-1:0]  push_idx
);
  import rs_pkg::*;

  logic full;
  logic ls_block;

  assign full = &occupied;
  assign ls_block = is_ls(req.opcode) && ls_count == ls_cnt_w'(rs_max_ls);
  assign fire = req.valid && !commit_flag && !clear && !full && !ls_block;

  // lowest free slot
  always_comb begin
    slot = '0;
    for (int i = rs_len - 1; i >= 0; i--) begin
      if (!occupied[i]) begin
        slot = rs_idx_w'(i);
      end
    end
  end

  always_comb begin
    entry.valid = 1'b1;
    entry.order = req.iq_idx;
    entry.opcode = req.opcode;
    entry.func3 = req.func3;
    entry.func7 = req.func7;
    entry.imm = req.imm;
    entry.pc = req.pc;
    entry.src1 = wake(src1, cdb);
    entry.src2 = wake(src2, cdb);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      push_valid <= 1'b0;
    end else begin
      push_valid <= fire;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      push_idx <= req.iq_idx;
    end
  end

endmodule

// File: src/station_entries.sv
`timescale 1ns/1ns

module station_entries (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        clear,
  input  logic                        alloc,
  input  logic [rs_pkg::rs_idx_w-1:0] alloc_slot,
  input  rs_pkg::rs_entry_t           alloc_entry,
  input  logic                        free,
  input  logic [rs_pkg::rs_idx_w-1:0] free_slot,
  input  rs_pkg::cdb_t                cdb,
  output rs_pkg::rs_entry_t           entries [rs_pkg::rs_len],
  output logic [rs_pkg::rs_len-1:0]   occupied,
  output logic [rs_pkg::ls_cnt_w-1:0] ls_count
);
  import rs_pkg::*;

  rs_entry_t slots [rs_len];
  logic ls_inc;
  logic ls_dec;

  assign ls_inc = alloc && is_ls(alloc_entry.opcode);
  assign ls_dec = free && is_ls(slots[free_slot].opcode);

  // occupancy is the authoritative valid flag
  always_comb begin
    for (int i = 0; i < rs_len; i++) begin
      entries[i] = slots[i];
      entries[i].valid = occupied[i];
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < rs_len; i++) begin
      slots[i].src1 <= wake(slots[i].src1, cdb);
      slots[i].src2 <= wake(slots[i].src2, cdb);
    end
    // the new entry already carries its own same-cycle wakeup
    if (alloc) begin
      slots[alloc_slot] <= alloc_entry;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      occupied <= '0;
      ls_count <= '0;
    end else begin
      if (free) begin
        occupied[free_slot] <= 1'b0;
      end
      if (alloc) begin
        occupied[alloc_slot] <= 1'b1;
      end
      ls_count <= ls_count + ls_cnt_w'(ls_inc) - ls_cnt_w'(ls_dec);
    end
  end

endmodule

// File: src/issue_stage.sv
`timescale 1ns/1ns

module issue_stage (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        clear,
  input  rs_pkg::rs_entry_t           entries [rs_pkg::rs_len],
  input  logic                        alu_full,
  input  logic                        lb_full,
  input  rs_pkg::store_order_t        order,
  output logic                        free,
  output logic [rs_pkg::rs_idx_w-1:0] free_slot,
  output rs_pkg::alu_req_t            alu,
  output rs_pkg::lb_req_t             lb,
  output rs_pkg::iq_write_t           iq_write
);
  import rs_pkg::*;

  logic [rs_len-1:0] ready;
  logic              found;
  rs_entry_t         s;
  calc_code_e        code;
  logic              is_alu;
  logic              is_load;
  alu_req_t          alu_next;
  lb_req_t           lb_next;
  iq_write_t         wb_next;

  // load may go only if it is older than the first pending store
  function automatic logic order_ok(store_order_t so, logic [iq_idx_w-1:0] ord);
    if (!so.have_store) begin
      return 1'b1;
    end
    if (so.head <= so.first_store) begin
      return so.head <= ord && ord < so.first_store;
    end
    return so.head <= ord || ord < so.first_store;
  endfunction

  function automatic calc_code_e decode(opcode_e op, logic [2:0] f3, logic [6:0] f7);
    if (op == op_branch) begin
      case (f3)
        3'd1: return calc_bne;
        3'd4: return calc_blt;
        3'd5: return calc_bge;
        3'd6: return calc_bltu;
        3'd7: return calc_bgeu;
        default: return calc_beq;
      endcase
    end
    case (f3)
      3'd0: return (op == op_calc && f7 != '0) ? calc_sub : calc_add;
      3'd1: return calc_sll;
      3'd2: return calc_slt;
      3'd3: return calc_sltu;
      3'd4: return calc_xor;
      3'd5: return (f7 != '0) ? calc_sra : calc_srl;
      3'd6: return calc_or;
      default: return calc_and;
    endcase
  endfunction

  always_comb begin
    for (int i = 0; i < rs_len; i++) begin
      ready[i] = 1'b0;
      if (entries[i].valid && !entries[i].src1.waiting && !entries[i].src2.waiting) begin
        case (entries[i].opcode)
          op_calc, op_calc_i, op_branch: ready[i] = !alu_full;
          op_load: ready[i] = !lb_full && order_ok(order, entries[i].order);
          op_store, op_lui, op_auipc, op_jal, op_jalr: ready[i] = 1'b1;
          default: ready[i] = 1'b0;
        endcase
      end
    end
  end

  always_comb begin
    free_slot = '0;
    for (int i = rs_len - 1; i >= 0; i--) begin
      if (ready[i]) begin
        free_slot = rs_idx_w'(i);
      end
    end
  end

  assign found = |ready;
  assign free = found && !clear;
  assign s = entries[free_slot];
  assign code = decode(s.opcode, s.func3, s.func7);
  assign is_alu = s.opcode inside {op_calc, op_calc_i, op_branch};
  assign is_load = s.opcode == op_load;

  always_comb begin
    alu_next.valid = free && is_alu;
    alu_next.code = code;
    alu_next.lhs = s.src1.value;
    alu_next.rhs = (s.opcode == op_calc_i) ? s.imm : s.src2.value;
    // shift amount is the low five bits
    if (code inside {calc_sll, calc_srl, calc_sra}) begin
      alu_next.rhs = {27'b0, alu_next.rhs[4:0]};
    end
    alu_next.iq_idx = s.order;

    lb_next.valid = free && is_load;
    lb_next.func3 = s.func3;
    lb_next.addr = s.src1.value + s.imm;
    lb_next.iq_idx = s.order;

    wb_next.valid = free && !is_alu && !is_load;
    wb_next.iq_idx = s.order;
    wb_next.result = s.pc + 32'd4;
    wb_next.need_cdb = 1'b1;
    wb_next.has_tar = 1'b0;
    wb_next.tar_addr = s.src1.value + s.imm;
    case (s.opcode)
      op_store: begin
        wb_next.result = s.src2.value;
        wb_next.need_cdb = 1'b0;
        wb_next.has_tar = 1'b1;
      end
      op_lui: wb_next.result = s.imm;
      op_auipc: wb_next.result = s.pc + s.imm;
      op_jalr: begin
        wb_next.has_tar = 1'b1;
        wb_next.tar_addr[0] = 1'b0;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    alu <= alu_next;
    lb <= lb_next;
    iq_write <= wb_next;
    if (rst) begin
      alu.valid <= 1'b0;
      lb.valid <= 1'b0;
      iq_write.valid <= 1'b0;
    end
  end

endmodule

// File: src/reservation_station.sv
`timescale 1ns/1ns

module reservation_station (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        clear,
  input  logic                        commit_flag,
  input  logic                        alu_full,
  input  logic                        lb_full,
  input  rs_pkg::dispatch_req_t       dispatch,
  input  rs_pkg::cdb_t                cdb,
  input  rs_pkg::commit_t             commit,
  input  rs_pkg::store_order_t        order,
  output logic                        push_valid,
  output logic [rs_pkg::iq_idx_w-1:0] push_idx,
  output rs_pkg::alu_req_t            alu,
  output rs_pkg::lb_req_t             lb,
  output rs_pkg::iq_write_t           iq_write
);
  import rs_pkg::*;

  operand_t            src1;
  operand_t            src2;
  logic                fire;
  logic [rs_idx_w-1:0] alloc_slot;
  rs_entry_t           alloc_entry;
  rs_entry_t           entries [rs_len];
  logic [rs_len-1:0]   occupied;
  logic [ls_cnt_w-1:0] ls_count;
  logic                free;
  logic [rs_idx_w-1:0] free_slot;

  operand_lookup operand_lookup_i (
    .clk, .rst, .clear, .fire,
    .rs1(dispatch.rs1), .rs2(dispatch.rs2), .rd(dispatch.rd), .tag(dispatch.iq_idx),
    .cdb, .commit, .src1, .src2
  );

  dispatch_stage dispatch_stage_i (
    .clk, .rst, .req(dispatch), .commit_flag, .clear, .occupied, .ls_count, .cdb,
    .src1, .src2, .fire, .slot(alloc_slot), .entry(alloc_entry), .push_valid, .push_idx
  );

  station_entries station_entries_i (
    .clk, .rst, .clear, .alloc(fire), .alloc_slot, .alloc_entry, .free, .free_slot,
    .cdb, .entries, .occupied, .ls_count
  );

  issue_stage issue_stage_i (
    .clk, .rst, .clear, .entries, .alu_full, .lb_full, .order, .free, .free_slot,
    .alu, .lb, .iq_write
  );

endmodule

// File: verification/rs_tb.sv
`timescale 1ns/1ns

module rs_tb;
  import rs_pkg::*;

  typedef enum logic [1:0] {kind_alu, kind_lb, kind_wb} kind_e;

  // one expected output with unused fields left at zero
  typedef struct packed {
    kind_e       kind;
    calc_code_e  code;
    logic [2:0]  func3;
    logic [31:0] a;
    logic [31:0] b;
    logic        need_cdb;
    logic        has_tar;
    logic [31:0] tar;
  } expect_t;

  logic                clk;
  logic                rst;
  logic                clear;
  logic                commit_flag;
  logic                alu_full;
  logic                lb_full;
  dispatch_req_t       dispatch;
  cdb_t                cdb;
  commit_t             commit;
  store_order_t        order;
  logic                push_valid;
  logic [iq_idx_w-1:0] push_idx;
  alu_req_t            alu;
  lb_req_t             lb;
  iq_write_t           iq_write;

  // scoreboard
  logic [31:0]       reg_model [reg_len];
  expect_t           exp_tab [iq_len];
  logic [iq_len-1:0] pending;
  logic [iq_len-1:0] issued;
  time               issue_time [iq_len];
  time               disp_time;
  int                mismatches;
  int                errors;
  logic [31:0]       rng_state;

  reservation_station reservation_station_i (
    .clk, .rst, .clear, .commit_flag, .alu_full, .lb_full, .dispatch, .cdb, .commit,
    .order, .push_valid, .push_idx, .alu, .lb, .iq_write
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function int rand_below(int n);
    return int'((next_rand() >> 8) % 32'(n));
  endfunction

  function automatic expect_t expect_issue(opcode_e op, logic [2:0] f3, logic [6:0] f7,
      logic [31:0] v1, logic [31:0] v2, logic [31:0] imm, logic [31:0] pc);
    expect_t e;
    e = '0;
    e.kind = kind_wb;
    e.need_cdb = 1'b1;
    case (op)
      op_load: begin
        e.kind = kind_lb;
        e.need_cdb = 1'b0;
        e.func3 = f3;
        e.a = v1 + imm;
      end
      op_store: begin
        e.a = v2;
        e.need_cdb = 1'b0;
        e.has_tar = 1'b1;
        e.tar = v1 + imm;
      end
      op_lui: e.a = imm;
      op_auipc: e.a = pc + imm;
      op_jal: e.a = pc + 32'd4;
      op_jalr: begin
        e.a = pc + 32'd4;
        e.has_tar = 1'b1;
        e.tar = (v1 + imm) & ~32'd1;
      end
      default: begin
        e.kind = kind_alu;
        e.need_cdb = 1'b0;
        e.a = v1;
        e.b = (op == op_calc_i) ? imm : v2;
        if (op == op_branch) begin
          case (f3)
            3'd1: e.code = calc_bne;
            3'd4: e.code = calc_blt;
            3'd5: e.code = calc_bge;
            3'd6: e.code = calc_bltu;
            3'd7: e.code = calc_bgeu;
            default: e.code = calc_beq;
          endcase
        end else begin
          case (f3)
            3'd0: e.code = (op == op_calc && f7 != 7'd0) ? calc_sub : calc_add;
            3'd1: e.code = calc_sll;
            3'd2: e.code = calc_slt;
            3'd3: e.code = calc_sltu;
            3'd4: e.code = calc_xor;
            3'd5: e.code = (f7 != 7'd0) ? calc_sra : calc_srl;
            3'd6: e.code = calc_or;
            default: e.code = calc_and;
          endcase
        end
        // shift amount only
        if (e.code == calc_sll || e.code == calc_srl || e.code == calc_sra) begin
          e.b = e.b & 32'h1f;
        end
      end
    endcase
    return e;
  endfunction

  function automatic dispatch_req_t make_req(logic [iq_idx_w-1:0] idx, opcode_e op,
      logic [2:0] f3, logic [reg_idx_w-1:0] rs1, logic [reg_idx_w-1:0] rs2,
      logic [reg_idx_w-1:0] rd, logic [31:0] imm);
    dispatch_req_t r;
    r = '{valid: 1'b1, iq_idx: idx, opcode: op, func3: f3, func7: 7'h00, imm: imm,
          rs1: rs1, rs2: rs2, rd: rd, pc: 32'h0000_1000 + {25'd0, idx, 2'b00}};
    return r;
  endfunction

  task automatic check_field(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      mismatches++;
      $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  task automatic check_pulse(logic [iq_idx_w-1:0] idx, expect_t got);
    expect_t e;
    e = exp_tab[idx];
    assert (pending[idx]) else begin
      errors++;
      $display("time %0t: output for iq_idx %0d without an outstanding instruction",
               $time, idx);
    end
    if (pending[idx]) begin
      check_field("issue path", 32'(got.kind), 32'(e.kind));
      if (got.kind == e.kind) begin
        case (e.kind)
          kind_alu: begin
            check_field("alu.code", 32'(got.code), 32'(e.code));
            check_field("alu.lhs", got.a, e.a);
            check_field("alu.rhs", got.b, e.b);
          end
          kind_lb: begin
            check_field("lb.func3", 32'(got.func3), 32'(e.func3));
            check_field("lb.addr", got.a, e.a);
          end
          default: begin
            check_field("iq_write.result", got.a, e.a);
            check_field("iq_write.need_cdb", 32'(got.need_cdb), 32'(e.need_cdb));
            check_field("iq_write.has_tar", 32'(got.has_tar), 32'(e.has_tar));
            if (e.has_tar) begin
              check_field("iq_write.tar_addr", got.tar, e.tar);
            end
          end
        endcase
      end
      pending[idx] = 1'b0;
      issued[idx] = 1'b1;
      issue_time[idx] = $time;
    end
  endtask

  // registered outputs are stable at the falling edge
  always @(negedge clk) begin : compare_outputs
    expect_t got;
    if (!rst) begin
      if (alu.valid) begin
        got = '0;
        got.kind = kind_alu;
        got.code = alu.code;
        got.a = alu.lhs;
        got.b = alu.rhs;
        check_pulse(alu.iq_idx, got);
      end
      if (lb.valid) begin
        got = '0;
        got.kind = kind_lb;
        got.func3 = lb.func3;
        got.a = lb.addr;
        check_pulse(lb.iq_idx, got);
      end
      if (iq_write.valid) begin
        got = '0;
        got.kind = kind_wb;
        got.a = iq_write.result;
        got.need_cdb = iq_write.need_cdb;
        got.has_tar = iq_write.has_tar;
        got.tar = iq_write.tar_addr;
        check_pulse(iq_write.iq_idx, got);
      end
    end
  end

  task automatic send_dispatch(dispatch_req_t req, logic [31:0] v1, logic [31:0] v2,
      logic ack, cdb_t bus);
    @(negedge clk);
    dispatch = req;
    cdb = bus;
    if (ack) begin
      exp_tab[req.iq_idx] = expect_issue(req.opcode, req.func3, req.func7, v1, v2,
                                         req.imm, req.pc);
      pending[req.iq_idx] = 1'b1;
      issued[req.iq_idx] = 1'b0;
    end
    disp_time = $time;
    @(negedge clk);
    dispatch.valid = 1'b0;
    cdb.valid = 1'b0;
    check_field("push_valid", 32'(push_valid), 32'(ack));
    if (ack) begin
      check_field("push_idx", 32'(push_idx), 32'(req.iq_idx));
    end
  endtask

  task automatic send_cdb(logic [iq_idx_w-1:0] tag, logic [31:0] value);
    @(negedge clk);
    cdb = '{valid: 1'b1, iq_idx: tag, value: value};
    @(negedge clk);
    cdb.valid = 1'b0;
  endtask

  task automatic send_commit(logic [reg_idx_w-1:0] rd, logic [iq_idx_w-1:0] tag,
      logic [31:0] value);
    @(negedge clk);
    commit = '{valid: 1'b1, rd: rd, iq_idx: tag, value: value};
    if (rd != '0) begin
      reg_model[rd] = value;
    end
    @(negedge clk);
    commit.valid = 1'b0;
  endtask

  task automatic wait_issue(logic [iq_idx_w-1:0] idx, int limit);
    int n;
    n = 0;
    while (!issued[idx] && n < limit) begin
      @(negedge clk);
      #1;
      n++;
    end
    assert (issued[idx]) else begin
      errors++;
      $display("time %0t: timeout waiting for the output of iq_idx %0d", $time, idx);
    end
  endtask

  task automatic expect_held(logic [iq_idx_w-1:0] idx, int cycles);
    repeat (cycles) @(negedge clk);
    #1;
    assert (!issued[idx] && pending[idx]) else begin
      errors++;
      $display("time %0t: iq_idx %0d left the station while it should be held", $time, idx);
    end
  endtask

  task automatic check_latency(logic [iq_idx_w-1:0] idx);
    assert (issue_time[idx] == disp_time + 16) else begin
      errors++;
      $display("time %0t: iq_idx %0d reached its output %0t ns after dispatch, not 16 ns",
               $time, idx, issue_time[idx] - disp_time);
    end
  endtask

  initial begin
    dispatch_req_t req;
    logic [31:0]   v;
    opcode_e       ops [9];
    rng_state = 32'd68;
    ops = '{op_load, op_store, op_calc, op_calc_i, op_branch, op_lui, op_auipc, op_jal,
            op_jalr};
    rst = 1'b1;
    clear = 1'b0;
    commit_flag = 1'b0;
    alu_full = 1'b0;
    lb_full = 1'b0;
    dispatch = '0;
    cdb = '0;
    commit = '0;
    order = '0;
    pending = '0;
    issued = '0;
    mismatches = 0;
    errors = 0;
    for (int r = 0; r < reg_len; r++) begin
      reg_model[r] = 32'd0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // committed operands with one instruction outstanding at a time
    for (int r = 1; r < reg_len; r++) begin
      send_commit(5'(r), 5'd0, next_rand());
    end
    for (int i = 0; i < 40; i++) begin
      req = '0;
      req.valid = 1'b1;
      req.iq_idx = 5'(i);
      req.opcode = ops[rand_below(9)];
      req.func3 = 3'(rand_below(8));
      if (req.opcode == op_branch && (req.func3 == 3'd2 || req.func3 == 3'd3)) begin
        req.func3 = req.func3 + 3'd2;
      end
      req.func7 = (rand_below(2) != 0) ? 7'h20 : 7'h00;
      req.rs1 = 5'(rand_below(32));
      req.rs2 = 5'(rand_below(32));
      req.rd = 5'(rand_below(32));
      req.imm = next_rand();
      req.pc = next_rand() & ~32'd3;
      send_dispatch(req, reg_model[req.rs1], reg_model[req.rs2], 1'b1, '0);
      wait_issue(req.iq_idx, 10);
      check_latency(req.iq_idx);
      send_commit(req.rd, req.iq_idx, next_rand());
    end

    // consumer of x5 waits for the broadcast of the renaming LUI
    send_dispatch(make_req(5'd1, op_lui, 3'd0, 5'd1, 5'd2, 5'd5, 32'h12345000),
                  reg_model[1], reg_model[2], 1'b1, '0);
    wait_issue(5'd1, 10);
    v = next_rand();
    send_dispatch(make_req(5'd2, op_calc, 3'd0, 5'd5, 5'd6, 5'd0, 32'd0),
                  v, reg_model[6], 1'b1, '0);
    expect_held(5'd2, 5);
    send_cdb(5'd1, v);
    wait_issue(5'd2, 10);
    send_commit(5'd5, 5'd1, v);
    // broadcast in the dispatch cycle
    send_dispatch(make_req(5'd3, op_lui, 3'd0, 5'd1, 5'd2, 5'd7, 32'habcde000),
                  reg_model[1], reg_model[2], 1'b1, '0);
    wait_issue(5'd3, 10);
    v = next_rand();
    send_dispatch(make_req(5'd4, op_calc_i, 3'd4, 5'd7, 5'd0, 5'd0, 32'h0f0f),
                  v, 32'd0, 1'b1, cdb_t'{valid: 1'b1, iq_idx: 5'd3, value: v});
    wait_issue(5'd4, 10);
    check_latency(5'd4);
    send_commit(5'd7, 5'd3, v);

    // direct kinds pass ALU entries held by back-pressure
    @(negedge clk);
    alu_full = 1'b1;
    send_dispatch(make_req(5'd8, op_calc, 3'd6, 5'd1, 5'd2, 5'd0, 32'd0),
                  reg_model[1], reg_model[2], 1'b1, '0);
    send_dispatch(make_req(5'd9, op_calc_i, 3'd1, 5'd3, 5'd0, 5'd0, 32'h7f),
                  reg_model[3], 32'd0, 1'b1, '0);
    send_dispatch(make_req(5'd10, op_lui, 3'd0, 5'd0, 5'd0, 5'd0, 32'h55555000),
                  32'd0, 32'd0, 1'b1, '0);
    send_dispatch(make_req(5'd11, op_store, 3'd2, 5'd4, 5'd5, 5'd0, 32'h40),
                  reg_model[4], reg_model[5], 1'b1, '0);
    wait_issue(5'd10, 10);
    wait_issue(5'd11, 10);
    expect_held(5'd8, 2);
    expect_held(5'd9, 0);
    @(negedge clk);
    alu_full = 1'b0;
    wait_issue(5'd8, 10);
    wait_issue(5'd9, 10);
    assert (issue_time[8] < issue_time[9]) else begin
      errors++;
      $display("time %0t: held ALU entries did not leave lowest slot first", $time);
    end
    // same for the load buffer
    @(negedge clk);
    lb_full = 1'b1;
    send_dispatch(make_req(5'd12, op_load, 3'd2, 5'd8, 5'd0, 5'd0, 32'h10),
                  reg_model[8], 32'd0, 1'b1, '0);
    send_dispatch(make_req(5'd13, op_load, 3'd4, 5'd9, 5'd0, 5'd0, 32'hfffffff0),
                  reg_model[9], 32'd0, 1'b1, '0);
    send_dispatch(make_req(5'd14, op_lui, 3'd0, 5'd0, 5'd0, 5'd0, 32'h0000a000),
                  32'd0, 32'd0, 1'b1, '0);
    wait_issue(5'd14, 10);
    expect_held(5'd12, 2);
    expect_held(5'd13, 0);
    @(negedge clk);
    lb_full = 1'b0;
    wait_issue(5'd12, 10);
    wait_issue(5'd13, 10);
    assert (issue_time[12] < issue_time[13]) else begin
      errors++;
      $display("time %0t: held loads did not leave lowest slot first", $time);
    end

    // station capacity with issue blocked
    @(negedge clk);
    alu_full = 1'b1;
    for (int k = 0; k < rs_len; k++) begin
      send_dispatch(make_req(5'(16 + k), op_calc, 3'(k), 5'(k + 1), 5'(k + 9), 5'd0, 32'd0),
                    reg_model[5'(k + 1)], reg_model[5'(k + 9)], 1'b1, '0);
    end
    send_dispatch(make_req(5'd24, op_calc, 3'd0, 5'd1, 5'd2, 5'd0, 32'd0),
                  reg_model[1], reg_model[2], 1'b0, '0);
    @(negedge clk);
    alu_full = 1'b0;
    for (int k = 0; k < rs_len; k++) begin
      wait_issue(5'(16 + k), 20);
    end
    // load/store cap followed by commit_flag
    @(negedge clk);
    lb_full = 1'b1;
    for (int k = 0; k < rs_max_ls; k++) begin
      send_dispatch(make_req(5'(25 + k), op_load, 3'd0, 5'(k + 1), 5'd0, 5'd0, 32'(k * 4)),
                    reg_model[5'(k + 1)], 32'd0, 1'b1, '0);
    end
    send_dispatch(make_req(5'd29, op_load, 3'd0, 5'd1, 5'd0, 5'd0, 32'd0),
                  reg_model[1], 32'd0, 1'b0, '0);
    send_dispatch(make_req(5'd30, op_store, 3'd2, 5'd1, 5'd2, 5'd0, 32'd0),
                  reg_model[1], reg_model[2], 1'b0, '0);
    @(negedge clk);
    commit_flag = 1'b1;
    send_dispatch(make_req(5'd31, op_lui, 3'd0, 5'd0, 5'd0, 5'd0, 32'h1000),
                  32'd0, 32'd0, 1'b0, '0);
    @(negedge clk);
    commit_flag = 1'b0;
    lb_full = 1'b0;
    for (int k = 0; k < rs_max_ls; k++) begin
      wait_issue(5'(25 + k), 20);
    end

    // store ordering with a plain range and then a wrapped one
    @(negedge clk);
    order = '{head: 5'd0, have_store: 1'b1, first_store: 5'd4};
    send_dispatch(make_req(5'd6, op_load, 3'd2, 5'd10, 5'd0, 5'd0, 32'h24),
                  reg_model[10], 32'd0, 1'b1, '0);
    send_dispatch(make_req(5'd2, op_load, 3'd1, 5'd11, 5'd0, 5'd0, 32'h8),
                  reg_model[11], 32'd0, 1'b1, '0);
    wait_issue(5'd2, 10);
    expect_held(5'd6, 4);
    @(negedge clk);
    order = '{head: 5'd28, have_store: 1'b1, first_store: 5'd2};
    send_dispatch(make_req(5'd30, op_load, 3'd5, 5'd12, 5'd0, 5'd0, 32'h30),
                  reg_model[12], 32'd0, 1'b1, '0);
    wait_issue(5'd30, 10);
    expect_held(5'd6, 2);
    @(negedge clk);
    order.have_store = 1'b0;
    wait_issue(5'd6, 10);

    // clear drops held entries and the stale rename of x10
    @(negedge clk);
    alu_full = 1'b1;
    send_dispatch(make_req(5'd8, op_calc, 3'd0, 5'd1, 5'd2, 5'd0, 32'd0),
                  reg_model[1], reg_model[2], 1'b1, '0);
    send_dispatch(make_req(5'd9, op_calc, 3'd7, 5'd3, 5'd4, 5'd10, 32'd0),
                  reg_model[3], reg_model[4], 1'b1, '0);
    @(negedge clk);
    clear = 1'b1;
    pending[8] = 1'b0;
    pending[9] = 1'b0;
    @(negedge clk);
    clear = 1'b0;
    alu_full = 1'b0;
    send_dispatch(make_req(5'd12, op_calc, 3'd0, 5'd10, 5'd11, 5'd0, 32'd0),
                  reg_model[10], reg_model[11], 1'b1, '0);
    wait_issue(5'd12, 10);
    check_latency(5'd12);
    repeat (6) @(negedge clk);

    $display("error counts: %0d mismatches, %0d other failures", mismatches, errors);
    if (mismatches == 0 && errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
src/rs_pkg.sv
src/operand_lookup.sv
src/dispatch_stage.sv
src/station_entries.sv
src/issue_stage.sv
src/reservation_station.sv
verification/rs_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rs_tb -f project.f \
  > build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/Vrs_tb > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST OK" sim.log || exit 1
exit 0
